//--- include/soc_io_ports.svh
//##################################################
// cpu bus port-list and connection macros
//##################################################
`ifndef SOC_IO_PORTS_SVH
`define SOC_IO_PORTS_SVH

// z80 native strobes as ansi port declarations
`define soc_io_cpu_ports \
	input  logic [15:0] cpu_addr, \
	input  logic [7:0]  cpu_dout, \
	input  logic        cpu_rd_n, \
	input  logic        cpu_wr_n, \
	input  logic        cpu_mreq_n, \
	input  logic        cpu_iorq_n, \
	input  logic        cpu_m1_n

// same signals as a by-name connection list
`define soc_io_cpu_connect \
	.cpu_addr   (cpu_addr), \
	.cpu_dout   (cpu_dout), \
	.cpu_rd_n   (cpu_rd_n), \
	.cpu_wr_n   (cpu_wr_n), \
	.cpu_mreq_n (cpu_mreq_n), \
	.cpu_iorq_n (cpu_iorq_n), \
	.cpu_m1_n   (cpu_m1_n)

`endif

//--- source/soc_io_pkg.sv
//##################################################
// port map, ps2 frame constants, scan codes, reset hold
//##################################################
package soc_io_pkg;

	// i/o port bases, keyboard ignores bit 0
	localparam logic [7:0] kbd_port = 8'h20;
	// mouse window is four ports, bits 1:0 pick the register
	localparam logic [7:0] mouse_port = 8'h30;
	localparam logic [1:0] mouse_ofs_x = 2'd0;
	localparam logic [1:0] mouse_ofs_y = 2'd1;

	// cpu stays in reset this many cycles after the last cause drops
	localparam logic [7:0] reset_hold = 8'd255;

	// start + 8 data + parity + stop
	localparam logic [3:0] ps2_frame_bits = 4'd11;
	// two flops on each ps2 line
	localparam integer ps2_sync_stages = 2;
	// no falling edge for this long means the frame is abandoned
	localparam integer ps2_idle_cycles = 4096;

	// set 2 prefixes
	localparam logic [7:0] release_code = 8'hF0;
	localparam logic [7:0] extend_code = 8'hE0;

	// bitmap bit order: space, s, w, a, d, q, e, enter
	localparam logic [7:0] key_codes [8] = '{
		8'h29,
		8'h1B,
		8'h1D,
		8'h1C,
		8'h23,
		8'h15,
		8'h24,
		8'h5A
	};

	// mouse header layout
	localparam integer hdr_sync_bit = 3;
	localparam integer hdr_xsign_bit = 4;
	localparam integer hdr_ysign_bit = 5;

	// sdram word address width on the memory port
	localparam integer mem_addr_bits = 25;

endpackage

//--- source/ps2_receiver.sv
//##################################################
// ps2 line synchronizer and checked 11-bit frame receiver
//##################################################
module ps2_receiver (
	input  logic       cpu_clock,
	input  logic       arst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	// synchronizer chains, newest sample in bit 0
	logic [soc_io_pkg::ps2_sync_stages-1:0] clk_sync;
	logic [soc_io_pkg::ps2_sync_stages-1:0] data_sync;
	logic clk_last;
	logic clk_s;
	logic data_s;
	logic clk_fall;

	// frame position and stall timer
	logic [3:0] bit_cnt;
	logic [$clog2(soc_io_pkg::ps2_idle_cycles)-1:0] idle_cnt;
	logic last_bit;
	logic idle_out;

	// start, data and parity bits, lsb first
	logic [soc_io_pkg::ps2_frame_bits-2:0] shift_q;
	logic frame_ok;

	assign clk_s = clk_sync[soc_io_pkg::ps2_sync_stages-1];
	assign data_s = data_sync[soc_io_pkg::ps2_sync_stages-1];
	assign clk_fall = clk_last & ~clk_s;

	assign last_bit = (bit_cnt == soc_io_pkg::ps2_frame_bits - 4'd1);
	assign idle_out = (idle_cnt == soc_io_pkg::ps2_idle_cycles - 1);

	// start low, odd parity over data+parity, stop (current bit) high
	assign frame_ok = ~shift_q[0] & (^shift_q[9:1]) & data_s;

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n) begin
			// idle ps2 lines sit high
			clk_sync <= '1;
			data_sync <= '1;
			clk_last <= 1'b1;
			bit_cnt <= 4'd0;
			idle_cnt <= '0;
			byte_valid <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[soc_io_pkg::ps2_sync_stages-2:0], ps2_clk};
			data_sync <= {data_sync[soc_io_pkg::ps2_sync_stages-2:0], ps2_data};
			clk_last <= clk_s;
			byte_valid <= 1'b0;
			if (clk_fall) begin
				idle_cnt <= '0;
				if (last_bit) begin
					// good or bad, the next edge starts a new frame
					bit_cnt <= 4'd0;
					byte_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (idle_out) begin
				// stalled mid-frame, drop what we have
				bit_cnt <= 4'd0;
			end else begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (clk_fall) begin
			shift_q <= {data_s, shift_q[9:1]};
			if (last_bit)
				byte_data <= shift_q[8:1];
		end
	end

	// one byte per frame, so the strobe can never be stretched
	a_valid_pulse: assert property (@(posedge cpu_clock) disable iff (!arst_n)
		byte_valid |=> !byte_valid)
		else $error("ps2_receiver: byte_valid high for two cycles");

endmodule

//--- source/key_decoder.sv
//##################################################
// scan code stream to eight-key bitmap
//##################################################
module key_decoder (
	input  logic       cpu_clock,
	input  logic       arst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output logic [7:0] keys
);

	// set by the break prefix, consumed by the next code byte
	logic release_q;
	logic is_release;
	logic is_extend;

	assign is_release = (byte_data == soc_io_pkg::release_code);
	assign is_extend = (byte_data == soc_io_pkg::extend_code);

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n) begin
			release_q <= 1'b0;
			keys <= 8'h00;
		end else if (byte_valid) begin
			if (is_release) begin
				release_q <= 1'b1;
			end else if (!is_extend) begin
				// e0 is transparent, everything else ends the prefix
				release_q <= 1'b0;
				for (int i = 0; i < 8; i++) begin
					if (byte_data == soc_io_pkg::key_codes[i])
						keys[i] <= ~release_q;
				end
			end
		end
	end

endmodule

//--- source/mouse_packet_fsm.sv
//##################################################
// three-byte ps2 mouse packet alignment
//##################################################
module mouse_packet_fsm (
	input  logic       cpu_clock,
	input  logic       arst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output logic       packet_valid,
	output logic [7:0] dx,
	output logic [7:0] dy,
	output logic [1:0] buttons
);

	typedef enum logic [1:0] {
		st_header,
		st_x,
		st_y
	} state_t;

	state_t state_q;

	// header and x byte kept until y arrives
	logic [7:0] hdr_q;
	logic [7:0] x_q;
	logic hdr_good;

	// bit 3 is always set in a real header byte
	assign hdr_good = byte_data[soc_io_pkg::hdr_sync_bit];

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= st_header;
			packet_valid <= 1'b0;
		end else begin
			packet_valid <= 1'b0;
			if (byte_valid) begin
				case (state_q)
					st_header: begin
						// anything else is a lost byte, keep hunting
						if (hdr_good)
							state_q <= st_x;
					end
					st_x: state_q <= st_y;
					st_y: begin
						state_q <= st_header;
						packet_valid <= 1'b1;
					end
					default: state_q <= st_header;
				endcase
			end
		end
	end

	always_ff @(posedge cpu_clock) begin
		if (byte_valid) begin
			case (state_q)
				st_header: begin
					if (hdr_good)
						hdr_q <= byte_data;
				end
				st_x: x_q <= byte_data;
				st_y: begin
					// msb replaced by the header sign bit
					dx <= {hdr_q[soc_io_pkg::hdr_xsign_bit], x_q[6:0]};
					dy <= {hdr_q[soc_io_pkg::hdr_ysign_bit], byte_data[6:0]};
					buttons <= hdr_q[1:0];
				end
				default: ;
			endcase
		end
	end

	a_hdr_synced: assert property (@(posedge cpu_clock) disable iff (!arst_n)
		packet_valid |-> hdr_q[soc_io_pkg::hdr_sync_bit])
		else $error("mouse_packet_fsm: packet from unsynced header");

endmodule

//--- source/mouse_accumulator.sv
//##################################################
// mouse movement sums with clear-on-read, buttons
//##################################################
module mouse_accumulator (
	input  logic       cpu_clock,
	input  logic       arst_n,
	input  logic       packet_valid,
	input  logic [7:0] dx,
	input  logic [7:0] dy,
	input  logic [1:0] buttons,
	input  logic       clr_x,
	input  logic       clr_y,
	output logic [7:0] mouse_x,
	output logic [7:0] mouse_y,
	output logic [1:0] mouse_b
);

	// starting point for this cycle, zero when the cpu just read it
	logic [7:0] base_x;
	logic [7:0] base_y;

	assign base_x = clr_x ? 8'h00 : mouse_x;
	assign base_y = clr_y ? 8'h00 : mouse_y;

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n) begin
			mouse_x <= 8'h00;
			mouse_y <= 8'h00;
			mouse_b <= 2'b00;
		end else if (packet_valid) begin
			// sums wrap at 256
			mouse_x <= base_x + dx;
			mouse_y <= base_y + dy;
			mouse_b <= buttons;
		end else begin
			mouse_x <= base_x;
			mouse_y <= base_y;
		end
	end

endmodule

//--- source/reset_sequencer.sv
//##################################################
// cpu reset hold counter
//##################################################
module reset_sequencer (
	input  logic       cpu_clock,
	input  logic       arst_n,
	input  logic       pll_locked,
	input  logic [7:0] status,
	input  logic       dio_download,
	output logic       cpu_reset
);

	logic [7:0] hold_cnt;
	logic cause;

	// status 0 is controller power-up, status 2 is the osd reset entry
	assign cause = ~pll_locked | status[0] | status[2] | dio_download;

	// cause feeds straight through so reset starts in the same cycle
	assign cpu_reset = cause | (hold_cnt < soc_io_pkg::reset_hold);

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n)
			hold_cnt <= 8'd0;
		else if (cause)
			hold_cnt <= 8'd0;
		else if (hold_cnt != soc_io_pkg::reset_hold)
			hold_cnt <= hold_cnt + 8'd1;
	end

	// rom download rewrites memory under the cpu, it must stay parked
	a_dl_reset: assert property (@(posedge cpu_clock) disable iff (!arst_n)
		dio_download |=> cpu_reset)
		else $error("reset_sequencer: cpu released right after download");

endmodule

//--- source/bus_decoder.sv
//##################################################
// i/o decode, read mux, clear pulses, memory steering
//##################################################
`include "soc_io_ports.svh"

module bus_decoder (
	input  logic                                cpu_clock,
	input  logic                                arst_n,
	`soc_io_cpu_ports,
	input  logic [7:0]                          keys,
	input  logic [7:0]                          mouse_x,
	input  logic [7:0]                          mouse_y,
	input  logic [1:0]                          mouse_b,
	output logic [7:0]                          cpu_din,
	output logic                                clr_x,
	output logic                                clr_y,
	input  logic                                dio_download,
	input  logic [soc_io_pkg::mem_addr_bits-1:0] dio_addr,
	input  logic [7:0]                          dio_data,
	input  logic                                dio_write,
	input  logic [7:0]                          mem_dout,
	output logic [soc_io_pkg::mem_addr_bits-1:0] mem_addr,
	output logic [7:0]                          mem_din,
	output logic                                mem_we,
	output logic                                mem_oe,
	output logic                                video_wr
);

	logic io_cycle;
	logic io_rd;
	logic kbd_sel;
	logic mouse_sel;
	logic [7:0] mouse_data;
	logic [7:0] io_dout;
	logic cpu_mem_wr;
	logic cpu_mem_rd;
	// which mouse sum the cpu was reading last cycle, {y, x}
	logic [1:0] rd_sel_q;

	// m1 low with iorq low is an interrupt ack, not a port access
	assign io_cycle = ~cpu_iorq_n & cpu_m1_n;
	assign io_rd = io_cycle & ~cpu_rd_n;
	assign kbd_sel = io_cycle & (cpu_addr[7:1] == soc_io_pkg::kbd_port[7:1]);
	assign mouse_sel = io_cycle & (cpu_addr[7:2] == soc_io_pkg::mouse_port[7:2]);

	// ports 2 and 3 of the window both give the buttons
	assign mouse_data = (cpu_addr[1:0] == soc_io_pkg::mouse_ofs_x) ? mouse_x :
		(cpu_addr[1:0] == soc_io_pkg::mouse_ofs_y) ? mouse_y : {6'b000000, mouse_b};

	assign io_dout = kbd_sel ? keys : mouse_sel ? mouse_data : 8'h00;
	assign cpu_din = ~cpu_iorq_n ? io_dout : mem_dout;

	// sum is cleared once the read strobe has gone away
	assign clr_x = rd_sel_q[0] & cpu_rd_n;
	assign clr_y = rd_sel_q[1] & cpu_rd_n;

	always_ff @(posedge cpu_clock or negedge arst_n) begin
		if (!arst_n) begin
			rd_sel_q <= 2'b00;
		end else begin
			rd_sel_q[0] <= io_rd & mouse_sel & (cpu_addr[1:0] == soc_io_pkg::mouse_ofs_x);
			rd_sel_q[1] <= io_rd & mouse_sel & (cpu_addr[1:0] == soc_io_pkg::mouse_ofs_y);
		end
	end

	assign cpu_mem_wr = ~cpu_mreq_n & ~cpu_wr_n;
	assign cpu_mem_rd = ~cpu_mreq_n & ~cpu_rd_n;

	// download helper owns the memory port while it runs
	assign mem_addr = dio_download ? dio_addr :
		{{(soc_io_pkg::mem_addr_bits - 16){1'b0}}, cpu_addr};
	assign mem_din = dio_download ? dio_data : cpu_dout;
	// ram sits in the upper 32k, video memory in the lower
	assign mem_we = dio_download ? dio_write : (cpu_mem_wr & cpu_addr[15]);
	assign mem_oe = dio_download | cpu_mem_rd;
	assign video_wr = ~dio_download & cpu_mem_wr & ~cpu_addr[15];

	a_one_target: assert property (@(posedge cpu_clock) disable iff (!arst_n)
		mem_we |-> !video_wr)
		else $error("bus_decoder: sdram and video written together");

endmodule

//--- source/soc_io.sv
//##################################################
// i/o and memory-steering subsystem top level
//##################################################
`include "soc_io_ports.svh"

module soc_io (
	input  logic                                cpu_clock,
	input  logic                                arst_n,
	`soc_io_cpu_ports,
	input  logic                                ps2_kbd_clk,
	input  logic                                ps2_kbd_data,
	input  logic                                ps2_mouse_clk,
	input  logic                                ps2_mouse_data,
	input  logic [7:0]                          status,
	input  logic                                pll_locked,
	input  logic                                dio_download,
	input  logic [soc_io_pkg::mem_addr_bits-1:0] dio_addr,
	input  logic [7:0]                          dio_data,
	input  logic                                dio_write,
	input  logic [7:0]                          mem_dout,
	output logic [7:0]                          cpu_din,
	output logic [soc_io_pkg::mem_addr_bits-1:0] mem_addr,
	output logic [7:0]                          mem_din,
	output logic                                mem_we,
	output logic                                mem_oe,
	output logic                                video_wr,
	output logic                                cpu_reset
);

	// keyboard byte stream
	logic [7:0] kbd_byte;
	logic kbd_valid;
	logic [7:0] keys;

	// mouse byte stream and packets
	logic [7:0] mouse_byte;
	logic mouse_valid;
	logic packet_valid;
	logic [7:0] dx;
	logic [7:0] dy;
	logic [1:0] buttons;

	// accumulated state seen by the cpu
	logic [7:0] mouse_x;
	logic [7:0] mouse_y;
	logic [1:0] mouse_b;
	logic clr_x;
	logic clr_y;

	ps2_receiver kbd_rx (
		.cpu_clock  (cpu_clock),
		.arst_n     (arst_n),
		.ps2_clk    (ps2_kbd_clk),
		.ps2_data   (ps2_kbd_data),
		.byte_data  (kbd_byte),
		.byte_valid (kbd_valid)
	);

	key_decoder key_dec (
		.cpu_clock  (cpu_clock),
		.arst_n     (arst_n),
		.byte_data  (kbd_byte),
		.byte_valid (kbd_valid),
		.keys       (keys)
	);

	ps2_receiver mouse_rx (
		.cpu_clock  (cpu_clock),
		.arst_n     (arst_n),
		.ps2_clk    (ps2_mouse_clk),
		.ps2_data   (ps2_mouse_data),
		.byte_data  (mouse_byte),
		.byte_valid (mouse_valid)
	);

	mouse_packet_fsm mouse_pkt (
		.cpu_clock    (cpu_clock),
		.arst_n       (arst_n),
		.byte_data    (mouse_byte),
		.byte_valid   (mouse_valid),
		.packet_valid (packet_valid),
		.dx           (dx),
		.dy           (dy),
		.buttons      (buttons)
	);

	mouse_accumulator mouse_acc (
		.cpu_clock    (cpu_clock),
		.arst_n       (arst_n),
		.packet_valid (packet_valid),
		.dx           (dx),
		.dy           (dy),
		.buttons      (buttons),
		.clr_x        (clr_x),
		.clr_y        (clr_y),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_b      (mouse_b)
	);

	reset_sequencer rst_seq (
		.cpu_clock    (cpu_clock),
		.arst_n       (arst_n),
		.pll_locked   (pll_locked),
		.status       (status),
		.dio_download (dio_download),
		.cpu_reset    (cpu_reset)
	);

	bus_decoder bus_dec (
		.cpu_clock    (cpu_clock),
		.arst_n       (arst_n),
		`soc_io_cpu_connect,
		.keys         (keys),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_b      (mouse_b),
		.cpu_din      (cpu_din),
		.clr_x        (clr_x),
		.clr_y        (clr_y),
		.dio_download (dio_download),
		.dio_addr     (dio_addr),
		.dio_data     (dio_data),
		.dio_write    (dio_write),
		.mem_dout     (mem_dout),
		.mem_addr     (mem_addr),
		.mem_din      (mem_din),
		.mem_we       (mem_we),
		.mem_oe       (mem_oe),
		.video_wr     (video_wr)
	);

endmodule

//--- tb/soc_io_tb.sv
//##################################################
// testbench: clock, reset, ps2 devices, cpu bus tasks
// reference model, compare tasks and checks
//##################################################
`include "soc_io_ports.svh"

module soc_io_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// run length, a key event is up to three frames
	localparam int key_events = 24;
	localparam int mouse_packets = 12;
	localparam int max_frames = key_events * 3 + 6 + mouse_packets * 3 + 1;
	localparam int timeout_cycles = max_frames * 11 * 80 + 2000;
	// 40 cycles per ps2 bit
	localparam int half_bit = 20;
	localparam int frame_gap = 40;

	logic cpu_clock;
	logic arst_n;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_rd_n;
	logic cpu_wr_n;
	logic cpu_mreq_n;
	logic cpu_iorq_n;
	logic cpu_m1_n;
	logic ps2_kbd_clk;
	logic ps2_kbd_data;
	logic ps2_mouse_clk;
	logic ps2_mouse_data;
	logic [7:0] status;
	logic pll_locked;
	logic dio_download;
	logic [soc_io_pkg::mem_addr_bits-1:0] dio_addr;
	logic [7:0] dio_data;
	logic dio_write;
	logic [7:0] mem_dout;
	logic [7:0] cpu_din;
	logic [soc_io_pkg::mem_addr_bits-1:0] mem_addr;
	logic [7:0] mem_din;
	logic mem_we;
	logic mem_oe;
	logic video_wr;
	logic cpu_reset;

	// reference model, bit 8 of key_state is the pending break prefix
	logic [8:0] key_state = 9'h000;
	logic [7:0] model_x = 8'h00;
	logic [7:0] model_y = 8'h00;
	logic [1:0] model_b = 2'b00;

	logic [31:0] rng_state = 32'd17;
	int check_count = 0;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;

	soc_io uut (
		.cpu_clock      (cpu_clock),
		.arst_n         (arst_n),
		`soc_io_cpu_connect,
		.ps2_kbd_clk    (ps2_kbd_clk),
		.ps2_kbd_data   (ps2_kbd_data),
		.ps2_mouse_clk  (ps2_mouse_clk),
		.ps2_mouse_data (ps2_mouse_data),
		.status         (status),
		.pll_locked     (pll_locked),
		.dio_download   (dio_download),
		.dio_addr       (dio_addr),
		.dio_data       (dio_data),
		.dio_write      (dio_write),
		.mem_dout       (mem_dout),
		.cpu_din        (cpu_din),
		.mem_addr       (mem_addr),
		.mem_din        (mem_din),
		.mem_we         (mem_we),
		.mem_oe         (mem_oe),
		.video_wr       (video_wr),
		.cpu_reset      (cpu_reset)
	);

	initial begin
		cpu_clock = 1'b0;
		forever #4 cpu_clock = ~cpu_clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task draw(output logic [31:0] v);
		rng_state = lcg_next(rng_state);
		v = rng_state;
	endtask

	// key bitmap after one scan code byte
	function automatic logic [8:0] key_step(input logic [8:0] st, input logic [7:0] code);
		logic [8:0] nx;
		int i;
		nx = st;
		if (code == soc_io_pkg::release_code) begin
			nx[8] = 1'b1;
		end else if (code != soc_io_pkg::extend_code) begin
			for (i = 0; i < 8; i++) begin
				if (code == soc_io_pkg::key_codes[i])
					nx[i] = ~st[8];
			end
			nx[8] = 1'b0;
		end
		return nx;
	endfunction

	// expected data of an i/o read
	function logic [7:0] port_expect(input logic [7:0] port);
		if (port[7:1] == soc_io_pkg::kbd_port[7:1])
			return key_state[7:0];
		if (port[7:2] == soc_io_pkg::mouse_port[7:2]) begin
			case (port[1:0])
				2'd0: return model_x;
				2'd1: return model_y;
				default: return {6'b000000, model_b};
			endcase
		end
		return 8'h00;
	endfunction

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		check_count++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_addr(input string name,
		input logic [soc_io_pkg::mem_addr_bits-1:0] got,
		input logic [soc_io_pkg::mem_addr_bits-1:0] exp);
		check_count++;
		if (got !== exp) begin
			value_errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("failure at %0t: %s", $time, what);
	endtask

	task print_totals;
		$display("checks %0d, value errors %0d, other failures %0d",
			check_count, value_errors, other_errors);
	endtask

	// every cpu read is checked while the strobe is low
	always @(negedge cpu_clock) begin
		if (arst_n && !cpu_iorq_n && !cpu_rd_n && cpu_m1_n)
			check_byte("cpu_din", cpu_din, port_expect(cpu_addr[7:0]));
		else if (arst_n && cpu_iorq_n && !cpu_mreq_n && !cpu_rd_n)
			check_byte("cpu_din", cpu_din, mem_dout);
	end

	always @(posedge cpu_clock) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("run stopped, not finished within %0d cycles", timeout_cycles);
			print_totals();
			$display("Test failures found");
			$finish;
		end
	end

	task drive_ps2(input logic mouse_dev, input logic clk, input logic data);
		@(posedge cpu_clock);
		if (mouse_dev) begin
			ps2_mouse_clk <= clk;
			ps2_mouse_data <= data;
		end else begin
			ps2_kbd_clk <= clk;
			ps2_kbd_data <= data;
		end
	endtask

	// device side of one frame, start bit first
	task automatic send_frame(input logic mouse_dev, input logic [7:0] value,
		input logic bad_parity, input logic bad_stop);
		logic [10:0] bits;
		logic seen;
		int i;
		int k;
		bits = {~bad_stop, ~(^value) ^ bad_parity, value, 1'b0};
		seen = 1'b0;
		for (i = 0; i < 11; i++) begin
			drive_ps2(mouse_dev, 1'b1, bits[i]);
			repeat (half_bit - 1) @(posedge cpu_clock);
			drive_ps2(mouse_dev, 1'b0, bits[i]);
			// byte strobe lands a few cycles after the falling edge
			for (k = 0; k < half_bit; k++) begin
				@(negedge cpu_clock);
				if (mouse_dev ? uut.mouse_valid : uut.kbd_valid)
					seen = 1'b1;
			end
		end
		drive_ps2(mouse_dev, 1'b1, 1'b1);
		repeat (frame_gap) @(posedge cpu_clock);
		if (!bad_parity && !bad_stop && !seen)
			report_failure($sformatf("ps2 byte 0x%h was not received", value));
		if ((bad_parity || bad_stop) && seen)
			report_failure("corrupt ps2 frame was accepted as a byte");
	endtask

	task send_key(input logic [7:0] code);
		send_frame(1'b0, code, 1'b0, 1'b0);
		key_state = key_step(key_state, code);
	endtask

	task send_packet(input logic [7:0] dx, input logic [7:0] dy, input logic [1:0] btn);
		logic [7:0] hdr;
		// sign bits in the header, sync bit 3 set
		hdr = {2'b00, dy[7], dx[7], 1'b1, 1'b0, btn};
		send_frame(1'b1, hdr, 1'b0, 1'b0);
		send_frame(1'b1, dx, 1'b0, 1'b0);
		send_frame(1'b1, dy, 1'b0, 1'b0);
		model_x = model_x + dx;
		model_y = model_y + dy;
		model_b = btn;
	endtask

	// two-cycle i/o read, sums clear the cycle after rd_n returns
	task io_read(input logic [7:0] port);
		logic [31:0] w;
		draw(w);
		@(posedge cpu_clock);
		cpu_addr <= {w[23:16], port};
		cpu_iorq_n <= 1'b0;
		cpu_rd_n <= 1'b0;
		cpu_m1_n <= 1'b1;
		@(posedge cpu_clock);
		@(posedge cpu_clock);
		cpu_iorq_n <= 1'b1;
		cpu_rd_n <= 1'b1;
		@(posedge cpu_clock);
		if (port == soc_io_pkg::mouse_port)
			model_x = 8'h00;
		if (port == soc_io_pkg::mouse_port + 8'd1)
			model_y = 8'h00;
	endtask

	task mem_write(input logic [15:0] addr, input logic [7:0] data);
		logic [soc_io_pkg::mem_addr_bits-1:0] exp_addr;
		exp_addr = '0;
		exp_addr[15:0] = addr;
		@(posedge cpu_clock);
		cpu_addr <= addr;
		cpu_dout <= data;
		cpu_mreq_n <= 1'b0;
		cpu_wr_n <= 1'b0;
		@(negedge cpu_clock);
		// upper half is sdram, lower half is video memory
		check_bit("mem_we", mem_we, addr[15]);
		check_bit("video_wr", video_wr, ~addr[15]);
		check_bit("mem_oe", mem_oe, 1'b0);
		check_addr("mem_addr", mem_addr, exp_addr);
		check_byte("mem_din", mem_din, data);
		@(posedge cpu_clock);
		cpu_mreq_n <= 1'b1;
		cpu_wr_n <= 1'b1;
	endtask

	task mem_read(input logic [15:0] addr, input logic [7:0] data);
		logic [soc_io_pkg::mem_addr_bits-1:0] exp_addr;
		exp_addr = '0;
		exp_addr[15:0] = addr;
		@(posedge cpu_clock);
		cpu_addr <= addr;
		mem_dout <= data;
		cpu_mreq_n <= 1'b0;
		cpu_rd_n <= 1'b0;
		@(negedge cpu_clock);
		check_bit("mem_oe", mem_oe, 1'b1);
		check_bit("mem_we", mem_we, 1'b0);
		check_bit("video_wr", video_wr, 1'b0);
		check_addr("mem_addr", mem_addr, exp_addr);
		@(posedge cpu_clock);
		cpu_mreq_n <= 1'b1;
		cpu_rd_n <= 1'b1;
	endtask

	// counts cycles of cpu_reset after the last cause was dropped
	task measure_release;
		int n;
		n = 0;
		@(negedge cpu_clock);
		while (cpu_reset === 1'b1 && n < 2 * soc_io_pkg::reset_hold) begin
			n++;
			@(negedge cpu_clock);
		end
		if (cpu_reset !== 1'b0)
			report_failure("cpu_reset was never released");
		else
			check_byte("cpu_reset hold cycles", n[7:0], soc_io_pkg::reset_hold);
	endtask

	task test_reset;
		@(negedge cpu_clock);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		@(posedge cpu_clock);
		pll_locked <= 1'b1;
		measure_release();
		// osd reset entry
		@(posedge cpu_clock);
		status <= 8'h04;
		@(negedge cpu_clock);
		check_bit("cpu_reset", cpu_reset, 1'b1);
		repeat (6) @(posedge cpu_clock);
		status <= 8'h00;
		measure_release();
	endtask

	task test_memory;
		logic [31:0] w;
		logic [31:0] w2;
		logic [soc_io_pkg::mem_addr_bits-1:0] exp_addr;
		logic [7:0] exp_data;
		int i;
		for (i = 0; i < 8; i++) begin
			draw(w);
			draw(w2);
			mem_write({i[0], w[30:16]}, w2[23:16]);
			mem_read(w2[31:16], w[23:16]);
		end
		// rom download takes over the memory port
		@(posedge cpu_clock);
		dio_download <= 1'b1;
		for (i = 0; i < 4; i++) begin
			draw(w);
			draw(w2);
			exp_addr = {w[24:16], w2[31:16]};
			exp_data = w2[23:16];
			@(posedge cpu_clock);
			dio_addr <= exp_addr;
			dio_data <= exp_data;
			dio_write <= 1'b1;
			@(negedge cpu_clock);
			check_addr("mem_addr", mem_addr, exp_addr);
			check_byte("mem_din", mem_din, exp_data);
			check_bit("mem_we", mem_we, 1'b1);
			check_bit("mem_oe", mem_oe, 1'b1);
			check_bit("video_wr", video_wr, 1'b0);
			check_bit("cpu_reset", cpu_reset, 1'b1);
		end
		@(posedge cpu_clock);
		dio_write <= 1'b0;
		@(negedge cpu_clock);
		check_bit("mem_we", mem_we, 1'b0);
		@(posedge cpu_clock);
		dio_download <= 1'b0;
		measure_release();
		// ports next to the windows read as zero
		io_read(8'h00);
		io_read(8'h1F);
		io_read(8'h22);
		io_read(8'h2F);
		io_read(8'h34);
		io_read(8'hFF);
	endtask

	task test_keys;
		logic [31:0] w;
		logic [7:0] code;
		int sel;
		int e;
		for (e = 0; e < key_events; e++) begin
			draw(w);
			sel = w[27:16] % 10;
			// 0x16 and 0x33 are not in the bitmap
			if (sel < 8)
				code = soc_io_pkg::key_codes[sel];
			else
				code = (sel == 8) ? 8'h16 : 8'h33;
			if (w[28] && w[31])
				send_key(soc_io_pkg::extend_code);
			if (w[29])
				send_key(soc_io_pkg::release_code);
			send_key(code);
			io_read(soc_io_pkg::kbd_port);
			io_read(soc_io_pkg::kbd_port + 8'd1);
		end
		// enter released, then two damaged make codes
		send_key(soc_io_pkg::release_code);
		send_key(soc_io_pkg::key_codes[7]);
		send_frame(1'b0, soc_io_pkg::key_codes[7], 1'b1, 1'b0);
		send_frame(1'b0, soc_io_pkg::key_codes[7], 1'b0, 1'b1);
		io_read(soc_io_pkg::kbd_port);
		io_read(soc_io_pkg::kbd_port + 8'd1);
		// receiver still in step after the bad frames
		send_key(soc_io_pkg::key_codes[7]);
		io_read(soc_io_pkg::kbd_port);
	endtask

	task read_mouse;
		io_read(soc_io_pkg::mouse_port + 8'd2);
		io_read(soc_io_pkg::mouse_port + 8'd3);
		io_read(soc_io_pkg::mouse_port);
		io_read(soc_io_pkg::mouse_port);
		io_read(soc_io_pkg::mouse_port + 8'd1);
		io_read(soc_io_pkg::mouse_port + 8'd1);
	endtask

	task test_mouse;
		logic [31:0] w;
		logic [31:0] w2;
		int p;
		// lost byte without the sync bit
		draw(w);
		send_frame(1'b1, w[23:16] & 8'hF7, 1'b0, 1'b0);
		for (p = 0; p < mouse_packets; p++) begin
			draw(w);
			draw(w2);
			send_packet(w[23:16], w2[23:16], w[30:29]);
			if (p % 3 == 2)
				read_mouse();
		end
	endtask

	initial begin
		arst_n = 1'b0;
		cpu_addr = 16'h0000;
		cpu_dout = 8'h00;
		cpu_rd_n = 1'b1;
		cpu_wr_n = 1'b1;
		cpu_mreq_n = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_m1_n = 1'b1;
		// idle ps2 lines are high
		ps2_kbd_clk = 1'b1;
		ps2_kbd_data = 1'b1;
		ps2_mouse_clk = 1'b1;
		ps2_mouse_data = 1'b1;
		status = 8'h00;
		pll_locked = 1'b0;
		dio_download = 1'b0;
		dio_addr = '0;
		dio_data = 8'h00;
		dio_write = 1'b0;
		mem_dout = 8'h00;
		repeat (8) @(posedge cpu_clock);
		arst_n <= 1'b1;
		test_reset();
		test_memory();
		test_keys();
		test_mouse();
		repeat (10) @(posedge cpu_clock);
		print_totals();
		if (value_errors == 0 && other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- soc_io.f
+incdir+include
source/soc_io_pkg.sv
source/ps2_receiver.sv
source/key_decoder.sv
source/mouse_packet_fsm.sv
source/mouse_accumulator.sv
source/reset_sequencer.sv
source/bus_decoder.sv
source/soc_io.sv
tb/soc_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the soc_io testbench with verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module soc_io_tb -f soc_io.f -o soc_io_sim

./obj_dir/soc_io_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"
